// ==== Makefile ====
# Verilator simulation of the FM channel testbench

VERILATOR ?= verilator
TOP       ?= tb_opl_channel
OBJ_DIR   ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
PASS_MSG  ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== list.f ====
logic/opl_pkg.sv
logic/opl_frame_seq.sv
logic/opl_wb_regs.sv
logic/opl_phase_gen.sv
logic/opl_operator.sv
logic/opl_channel_alg.sv
logic/opl_channel.sv
verif/tb_opl_channel.sv

// ==== logic/opl_channel.sv ====
/*
 * Top level of the two-operator FM channel with a Wishbone register port.
 * Emits one signed 16-bit sample per frame with a one-cycle valid strobe.
 */
`default_nettype none

module opl_channel (
    input  wire                 clk,
    input  wire                 rst_n,
    input  opl_pkg::wb_req_t    wb_req,
    output opl_pkg::wb_rsp_t    wb_rsp,
    output opl_pkg::sample_t    sample,
    output logic                sample_valid
);
    import opl_pkg::*;

    logic [SLOT_W-1:0] slot;
    chan_cfg_t         cfg;
    logic [IDX_W-1:0]  phase_index;
    op_req_t           op_req;
    op_rsp_t           op_rsp;

    // ------------------------------------------------------------------------
    // frame pacing and registers
    // ------------------------------------------------------------------------
    opl_frame_seq u_frame_seq (
        .clk          (clk),
        .rst_n        (rst_n),
        .slot         (slot)
    );

    opl_wb_regs u_wb_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .slot         (slot),
        .cfg          (cfg)
    );

    // ------------------------------------------------------------------------
    // phase, algorithm and the shared operator
    // ------------------------------------------------------------------------
    opl_phase_gen u_phase_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .slot         (slot),
        .cfg          (cfg),
        .phase_index  (phase_index)
    );

    opl_channel_alg u_channel_alg (
        .clk          (clk),
        .rst_n        (rst_n),
        .slot         (slot),
        .cfg          (cfg),
        .phase_index  (phase_index),
        .op_req       (op_req),
        .op_rsp       (op_rsp),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    opl_operator op_pipe (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (op_req),
        .rsp          (op_rsp)
    );

endmodule

`default_nettype wire

// ==== logic/opl_channel_alg.sv ====
/*
 * Channel algorithm: issues modulator and carrier requests per frame,
 * keeps the modulator feedback history and forms the output sample.
 */
`default_nettype none

module opl_channel_alg (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire [opl_pkg::SLOT_W-1:0]   slot,
    input  opl_pkg::chan_cfg_t          cfg,
    input  wire [opl_pkg::IDX_W-1:0]    phase_index,
    output opl_pkg::op_req_t            op_req,
    input  opl_pkg::op_rsp_t            op_rsp,
    output opl_pkg::sample_t            sample,
    output logic                        sample_valid
);
    import opl_pkg::*;

    sample_t                 hist0;              // last modulator output
    sample_t                 hist1;              // the one before
    logic signed [SAMPLE_W:0] fb_sum;
    logic signed [SAMPLE_W:0] fb_shifted;
    sample_t                 mod_shifted;
    logic [IDX_W-1:0]        fb_off;
    logic [IDX_W-1:0]        car_off;

    // ------------------------------------------------------------------------
    // index offsets
    // ------------------------------------------------------------------------
    assign fb_sum      = 17'(hist0) + 17'(hist1);
    assign fb_shifted  = fb_sum >>> (4'd10 - {1'b0, cfg.feedback});
    assign fb_off      = (cfg.feedback == '0) ? '0 : fb_shifted[IDX_W-1:0];
    assign mod_shifted = hist0 >>> MOD_SHIFT;
    assign car_off     = cfg.additive ? '0 : mod_shifted[IDX_W-1:0];

    always_comb begin
        op_req = '0;
        if (slot == MOD_SLOT) begin
            op_req.valid  = 1'b1;
            op_req.phase  = phase_index;
            op_req.offset = fb_off;
            op_req.level  = cfg.level_mod;
        end else if (slot == CAR_SLOT) begin
            op_req.valid   = 1'b1;
            op_req.carrier = 1'b1;
            op_req.phase   = phase_index;
            op_req.offset  = car_off;
            op_req.level   = cfg.level_car;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hist0 <= '0;
            hist1 <= '0;
        end else if (op_rsp.valid && !op_rsp.carrier) begin
            hist1 <= hist0;
            hist0 <= op_rsp.value;
        end
    end

    // carrier result is on op_rsp the cycle before SAMPLE_SLOT
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sample       <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= (slot == SAMPLE_SLOT - SLOT_W'(1));
            if (slot == SAMPLE_SLOT - SLOT_W'(1)) begin
                sample <= cfg.additive ? sat_add(hist0, op_rsp.value) : op_rsp.value;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/opl_frame_seq.sv ====
/*
 * Free-running slot counter that paces every stage of the channel.
 * One sample frame is FRAME_CYCLES clock cycles long.
 */
`default_nettype none

module opl_frame_seq (
    input  wire                       clk,
    input  wire                       rst_n,
    output logic [opl_pkg::SLOT_W-1:0] slot
);
    import opl_pkg::*;

    logic last_slot;

    assign last_slot = (slot == SLOT_W'(FRAME_CYCLES - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot <= '0;
        end else if (last_slot) begin
            slot <= '0;                          // new frame
        end else begin
            slot <= slot + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/opl_operator.sv ====
/*
 * Time-shared operator pipeline, used for modulator and carrier in turn.
 * Stage 1 looks up the sine of phase plus offset, stage 2 applies the level.
 * Accepts one request per cycle; results appear OP_LATENCY cycles later.
 */
`default_nettype none

module opl_operator (
    input  wire                 clk,
    input  wire                 rst_n,
    input  opl_pkg::op_req_t    req,
    output opl_pkg::op_rsp_t    rsp
);
    import opl_pkg::*;

    logic [IDX_W-1:0]   idx;

    // stage 1
    logic               s1_valid;
    logic               s1_carrier;
    sample_t            s1_value;
    logic [LEVEL_W-1:0] s1_level;

    // stage 2
    logic               s2_valid;
    logic               s2_carrier;
    sample_t            s2_value;

    assign idx = req.phase + req.offset;         // mod 1024

    // ------------------------------------------------------------------------
    // stage 1, sine lookup
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= req.valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_carrier <= req.carrier;
        s1_level   <= req.level;
        s1_value   <= sine_of(idx);
    end

    // ------------------------------------------------------------------------
    // stage 2, level attenuation by arithmetic shift
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s2_carrier <= s1_carrier;
        s2_value   <= s1_value >>> s1_level;     // 6 dB per step
    end

    always_comb begin
        rsp.valid   = s2_valid;
        rsp.carrier = s2_carrier;
        rsp.value   = s2_value;
    end

endmodule

`default_nettype wire

// ==== logic/opl_phase_gen.sv ====
/*
 * Shared phase accumulator for both operators.
 * The step is fnum shifted left by the octave block; advances once per frame.
 */
`default_nettype none

module opl_phase_gen (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire [opl_pkg::SLOT_W-1:0]   slot,
    input  opl_pkg::chan_cfg_t          cfg,
    output logic [opl_pkg::IDX_W-1:0]   phase_index
);
    import opl_pkg::*;

    logic [PHASE_W-1:0] phase;
    logic [PHASE_W-1:0] step;

    // ------------------------------------------------------------------------
    // block shift, fnum << octave fits in 17 bits
    // ------------------------------------------------------------------------
    assign step = PHASE_W'(cfg.fnum) << cfg.octave;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (slot == PHASE_SLOT) begin
            phase <= phase + step;               // wraps mod 2^20
        end
    end

    assign phase_index = phase[PHASE_W-1 -: IDX_W];

endmodule

`default_nettype wire

// ==== logic/opl_pkg.sv ====
/*
 * Shared constants, register map, bus and pipeline structs for the FM channel.
 * Every RTL file imports this package; the sine and saturation rules live here.
 */
`default_nettype none

package opl_pkg;

    // ------------------------------------------------------------------------
    // frame timing
    // ------------------------------------------------------------------------
    localparam int SLOT_W       = 6;
    localparam int FRAME_CYCLES = 64;
    localparam int OP_LATENCY   = 2;             // request to result

    localparam logic [SLOT_W-1:0] LOAD_SLOT   = 6'd2;
    localparam logic [SLOT_W-1:0] PHASE_SLOT  = 6'd4;
    localparam logic [SLOT_W-1:0] MOD_SLOT    = 6'd6;
    localparam logic [SLOT_W-1:0] CAR_SLOT    = 6'd10;
    localparam logic [SLOT_W-1:0] SAMPLE_SLOT = CAR_SLOT + SLOT_W'(OP_LATENCY) + 6'd1;

    // ------------------------------------------------------------------------
    // field widths
    // ------------------------------------------------------------------------
    localparam int FNUM_W    = 10;
    localparam int OCT_W     = 3;
    localparam int FB_W      = 3;
    localparam int LEVEL_W   = 4;
    localparam int PHASE_W   = 20;
    localparam int IDX_W     = 10;               // sine index, top of the phase
    localparam int SAMPLE_W  = 16;
    localparam int MOD_SHIFT = 5;                // modulator sample to index offset

    // register map
    localparam int ADR_W = 3;
    localparam int DAT_W = 8;

    localparam logic [ADR_W-1:0] REG_FNUM_LO   = 3'd0;
    localparam logic [ADR_W-1:0] REG_BLOCK     = 3'd1;
    localparam logic [ADR_W-1:0] REG_FB_CONN   = 3'd2;
    localparam logic [ADR_W-1:0] REG_LEVEL_MOD = 3'd3;
    localparam logic [ADR_W-1:0] REG_LEVEL_CAR = 3'd4;

    // ------------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------------
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    typedef struct packed {
        logic [FNUM_W-1:0]  fnum;
        logic [OCT_W-1:0]   octave;
        logic [FB_W-1:0]    feedback;
        logic               additive;            // 1 = both operators summed
        logic [LEVEL_W-1:0] level_mod;
        logic [LEVEL_W-1:0] level_car;
    } chan_cfg_t;

    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [ADR_W-1:0] adr;
        logic [DAT_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic             ack;
        logic [DAT_W-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic               valid;
        logic               carrier;
        logic [IDX_W-1:0]   phase;
        logic [IDX_W-1:0]   offset;
        logic [LEVEL_W-1:0] level;
    } op_req_t;

    typedef struct packed {
        logic    valid;
        logic    carrier;
        sample_t value;
    } op_rsp_t;

    // parabolic quarter wave, mirrored by bit 8 and signed by bit 9
    function automatic sample_t sine_of(input logic [IDX_W-1:0] idx);
        logic [7:0]  q;
        logic [16:0] prod;
        logic [15:0] mag;
        q    = idx[8] ? ~idx[7:0] : idx[7:0];
        prod = {9'd0, q} * (17'd511 - {9'd0, q});
        mag  = prod[16:1];                       // peak 32640
        return idx[9] ? sample_t'(-$signed(mag)) : sample_t'($signed(mag));
    endfunction

    function automatic sample_t sat_add(input sample_t a, input sample_t b);
        logic signed [SAMPLE_W:0] sum;
        sum = 17'(a) + 17'(b);
        if (sum > 17'sd32767) begin
            return 16'sh7FFF;
        end else if (sum < -17'sd32768) begin
            return 16'sh8000;
        end
        return sample_t'(sum[SAMPLE_W-1:0]);
    endfunction

endpackage

`default_nettype wire

// ==== logic/opl_wb_regs.sv ====
/*
 * Wishbone classic slave with the channel's awaiting register set.
 * The awaiting set is copied whole into the live cfg once per frame.
 */
`default_nettype none

module opl_wb_regs (
    input  wire                           clk,
    input  wire                           rst_n,
    input  opl_pkg::wb_req_t              wb_req,
    output opl_pkg::wb_rsp_t              wb_rsp,
    input  wire [opl_pkg::SLOT_W-1:0]     slot,
    output opl_pkg::chan_cfg_t            cfg
);
    import opl_pkg::*;

    chan_cfg_t        pend;                      // awaiting values
    logic             access;
    logic             wr_en;
    logic [DAT_W-1:0] rd_data;

    // one ack per transfer, master drops stb after seeing it
    assign access = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
    assign wr_en  = access && wb_req.we;

    // ------------------------------------------------------------------------
    // read mux, register bit layout
    // ------------------------------------------------------------------------
    always_comb begin
        case (wb_req.adr)
            REG_FNUM_LO:   rd_data = pend.fnum[7:0];
            REG_BLOCK:     rd_data = {3'b000, pend.octave, pend.fnum[9:8]};
            REG_FB_CONN:   rd_data = {4'b0000, pend.feedback, pend.additive};
            REG_LEVEL_MOD: rd_data = {4'b0000, pend.level_mod};
            REG_LEVEL_CAR: rd_data = {4'b0000, pend.level_car};
            default:       rd_data = '0;         // 5..7 unmapped
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_rsp <= '0;
        end else begin
            wb_rsp.ack <= access;
            if (access) begin
                wb_rsp.dat <= rd_data;
            end
        end
    end

    // ------------------------------------------------------------------------
    // awaiting set
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend <= '0;
        end else if (wr_en) begin
            case (wb_req.adr)
                REG_FNUM_LO:   pend.fnum[7:0] <= wb_req.dat;
                REG_BLOCK: begin
                    pend.fnum[9:8] <= wb_req.dat[1:0];
                    pend.octave    <= wb_req.dat[4:2];
                end
                REG_FB_CONN: begin
                    pend.feedback <= wb_req.dat[3:1];
                    pend.additive <= wb_req.dat[0];
                end
                REG_LEVEL_MOD: pend.level_mod <= wb_req.dat[3:0];
                REG_LEVEL_CAR: pend.level_car <= wb_req.dat[3:0];
                default:       pend <= pend;     // ignored
            endcase
        end
    end

    // live set, whole copy so fnum never goes half updated
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= '0;
        end else if (slot == LOAD_SLOT) begin
            cfg <= pend;
        end
    end

endmodule

`default_nettype wire

// ==== verif/opl_stim.txt ====
# kind addr value, all numbers hex
# W writes a register, R reads and expects the value, F runs that many frames
R 0 00
R 1 00
R 2 00
R 3 00
R 4 00
R 7 00
F 2
W 0 5a
W 1 09
W 3 02
W 4 01
W 2 00
R 0 5a
R 1 09
R 2 00
R 3 02
R 4 01
F 6
W 2 0a
W 1 1e
R 2 0a
F 8
W 2 ff
R 2 0f
W 5 ff
R 5 00
R 6 00
W 3 00
W 4 00
W 2 01
W 1 1c
W 0 ab
R 1 1c
F 30
R 2 01
F 4

// ==== verif/tb_opl_channel.sv ====
/*
 * Testbench for the FM channel: runs the transfers and frames listed in
 * verif/opl_stim.txt and checks reads, ack timing and every sample.
 */
`default_nettype none

module tb_opl_channel;
    timeunit 1ns;
    timeprecision 100ps;
    import opl_pkg::*;

    localparam logic [31:0] SEED = 32'h8423_0281;

    logic      clk = 1'b0;
    logic      rst_n;
    wb_req_t   wb_req;
    wb_rsp_t   wb_rsp;
    sample_t   sample;
    logic      sample_valid;

    byte       kinds[$];                         // parsed stimulus lines
    int        arg_a[$];
    int        arg_b[$];
    int        transfers = 0;
    int        frames = 0;
    int        limit = 0;                        // watchdog cycles
    int        reg_errors = 0;
    int        sample_errors = 0;
    int        samples_seen = 0;
    logic      loaded = 1'b0;
    logic [31:0] rng;

    // reference model state
    chan_cfg_t         pend_m;
    chan_cfg_t         live_m;
    logic [SLOT_W-1:0] slot_m;
    logic              ack_exp = 1'b0;
    int                phase;
    int                hist0;
    int                hist1;
    int                exp_sample;

    opl_channel UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    always #2 clk = ~clk;                        // 4 ns period

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // parabola over a quarter wave, mirrored and signed by the top bits
    function automatic int sine_rule(input int idx);
        int q;
        int mag;
        q = idx & 255;
        if ((idx & 256) != 0) begin
            q = 255 - q;
        end
        mag = (q * (511 - q)) / 2;
        return ((idx & 512) != 0) ? -mag : mag;
    endfunction

    function automatic int operator_out(input int idx, input int off, input int level);
        return sine_rule((idx + off) & 1023) >>> level;
    endfunction

    function automatic int saturate(input int s);
        if (s > 32767) begin
            return 32767;
        end else if (s < -32768) begin
            return -32768;
        end
        return s;
    endfunction

    task automatic check_reg(input wb_rsp_t got, input wb_rsp_t exp, input string what);
        if (got !== exp) begin
            reg_errors++;
            $display("error %0t ns: %s returned ack %b data %h, expected ack %b data %h",
                     $time, what, got.ack, got.dat, exp.ack, exp.dat);
        end
    endtask

    task automatic check_sample(input sample_t got, input sample_t exp);
        if (got !== exp) begin
            sample_errors++;
            $display("error %0t ns: sample %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic store_write(input logic [ADR_W-1:0] adr, input logic [DAT_W-1:0] dat);
        case (adr)
            REG_FNUM_LO:   pend_m.fnum[7:0] = dat;
            REG_BLOCK: begin
                pend_m.fnum[9:8] = dat[1:0];
                pend_m.octave    = dat[4:2];
            end
            REG_FB_CONN: begin
                pend_m.feedback = dat[3:1];
                pend_m.additive = dat[0];
            end
            REG_LEVEL_MOD: pend_m.level_mod = dat[3:0];
            REG_LEVEL_CAR: pend_m.level_car = dat[3:0];
            default:       ;                     // unmapped, nothing stored
        endcase
    endtask

    // ------------------------------------------------------------------------
    // stimulus file and bus driver
    // ------------------------------------------------------------------------
    task automatic load_stimulus();
        int    fd;
        int    n;
        string line;
        byte   kind;
        int    a;
        int    b;
        fd = $fopen("verif/opl_stim.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line.substr(0, 0) != "#") begin
                b = 0;
                n = $sscanf(line, "%c %h %h", kind, a, b);
                kinds.push_back(kind);
                arg_a.push_back(a);
                arg_b.push_back(b);
                if (kind == "F") begin
                    frames += a;
                end else begin
                    transfers++;
                end
            end
        end
        $fclose(fd);
        loaded = 1'b1;
    endtask

    task automatic bus_transfer(input logic we, input int adr, input int dat,
                                output wb_rsp_t rsp);
        int waited;
        rng = xorshift32(rng);
        repeat (int'(rng[2:0])) @(posedge clk);  // idle 0..7 cycles
        @(posedge clk);
        #1;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: ADR_W'(adr), dat: DAT_W'(dat)};
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wb_rsp.ack && waited < 8);
        if (!wb_rsp.ack) begin
            reg_errors++;
            $display("no ack for the transfer to address %0d at %0t ns", adr, $time);
        end
        rsp = wb_rsp;
        wb_req = '0;
    endtask

    task automatic run_line(input int i);
        wb_rsp_t rsp;
        if (kinds[i] == "W") begin
            bus_transfer(1'b1, arg_a[i], arg_b[i], rsp);
        end else if (kinds[i] == "R") begin
            bus_transfer(1'b0, arg_a[i], 0, rsp);
            check_reg(rsp, '{ack: 1'b1, dat: DAT_W'(arg_b[i])},
                      $sformatf("read of register %0d", arg_a[i]));
        end else begin
            repeat (arg_a[i] * FRAME_CYCLES) @(posedge clk);
        end
    endtask

    // ------------------------------------------------------------------------
    // reference model, evaluated mid cycle for the edge that ends the slot
    // ------------------------------------------------------------------------
    always @(negedge clk) begin : model
        logic access;
        int   off;
        int   car;
        if (wb_rsp.ack !== ack_exp) begin
            reg_errors++;
            $display("error %0t ns: ack was %b where %b was due", $time, wb_rsp.ack, ack_exp);
        end
        if (sample_valid !== (rst_n && slot_m == SAMPLE_SLOT)) begin
            sample_errors++;
            $display("error %0t ns: sample_valid was %b in slot %0d",
                     $time, sample_valid, slot_m);
        end
        if (!rst_n) begin
            slot_m = '0;
            ack_exp = 1'b0;
            pend_m = '0;
            live_m = '0;
            phase = 0;
            hist0 = 0;
            hist1 = 0;
            exp_sample = 0;
        end else begin
            if (slot_m == SAMPLE_SLOT && sample_valid) begin
                check_sample(sample, sample_t'(exp_sample));
                samples_seen++;
            end
            if (slot_m == LOAD_SLOT) begin
                live_m = pend_m;                 // commit before this edge's write
            end
            access = wb_req.cyc && wb_req.stb && !ack_exp;
            if (access && wb_req.we) begin
                store_write(wb_req.adr, wb_req.dat);
            end
            ack_exp = access;
            if (slot_m == PHASE_SLOT) begin
                phase = (phase + (int'(live_m.fnum) << live_m.octave)) & 32'h000F_FFFF;
            end
            if (slot_m == MOD_SLOT) begin
                off = 0;
                if (live_m.feedback != 0) begin
                    off = ((hist0 + hist1) >>> (10 - int'(live_m.feedback))) & 1023;
                end
                hist1 = hist0;
                hist0 = operator_out(phase >> 10, off, int'(live_m.level_mod));
            end
            if (slot_m == CAR_SLOT) begin
                off = live_m.additive ? 0 : (hist0 >>> MOD_SHIFT) & 1023;
                car = operator_out(phase >> 10, off, int'(live_m.level_car));
                exp_sample = live_m.additive ? saturate(hist0 + car) : car;
            end
            slot_m = (slot_m == SLOT_W'(FRAME_CYCLES - 1)) ? '0 : slot_m + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // main sequence and watchdog
    // ------------------------------------------------------------------------
    initial begin
        wb_req = '0;
        rst_n = 1'b0;
        rng = SEED;
        load_stimulus();
        if (!loaded) begin
            $display("could not open verif/opl_stim.txt for reading");
            $display("Something failed");
            $finish;
        end else begin
            limit = 2 * (16 + 12 * transfers + FRAME_CYCLES * frames);
            repeat (16) @(posedge clk);
            #1;
            rst_n = 1'b1;
            foreach (kinds[i]) begin
                run_line(i);
            end
            @(posedge clk);
            if (samples_seen == 0) begin
                sample_errors++;
                $display("no sample was ever checked");
            end
            $display("register errors %0d, sample errors %0d", reg_errors, sample_errors);
            if (reg_errors == 0 && sample_errors == 0) begin
                $display("Everything OK");
            end else begin
                $display("Something failed");
            end
            $finish;
        end
    end

    initial begin
        wait (limit > 0);
        repeat (limit) @(posedge clk);
        $display("timeout, the run did not finish within %0d cycles", limit);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire
